/* verilog/tcp_pkg.sv */
package tcp_pkg;

    // ------------------------------------------------------------------------
    // Field widths
    // ------------------------------------------------------------------------
    localparam int SEQ_W  = 32;         // Sequence and ack numbers
    localparam int LEN_W  = 16;         // Payload length in bytes
    localparam int FLAG_W = 8;          // TCP flags byte

    // Bit positions inside the flags byte
    localparam int FLAG_FIN = 0;
    localparam int FLAG_SYN = 1;
    localparam int FLAG_RST = 2;
    localparam int FLAG_PSH = 3;
    localparam int FLAG_ACK = 4;

    // ------------------------------------------------------------------------
    // Connection states
    // ------------------------------------------------------------------------
    typedef enum logic [3:0] {
        CLOSED,                         // Idle, waits for CONNECT
        SYN_SENT,                       // SYN out, waits for SYN+ACK
        ESTABLISHED,                    // Data transfer
        FIN_WAIT_1,                     // Our FIN out, not yet acked
        FIN_WAIT_2,                     // Our FIN acked, waits for peer FIN
        TIME_WAIT,                      // Final ACK out, quiet period
        SEND_SEG,                       // Header loaded, start pulse
        WAIT_SEND,                      // Sender still busy
        CLOSING_ACK                     // Reserved encoding
    } tcp_state_e;

    // Application command
    typedef enum logic [1:0] {
        CONNECT,
        SEND,
        CLOSE
    } cmd_op_e;

    // Kind of header the tracker builds
    typedef enum logic [2:0] {
        SYN,                            // Opening SYN, seq = ISN
        ACK,                            // Plain ACK
        DATA,                           // ACK+PSH with payload
        FIN,                            // FIN+ACK
        DUP_ACK                         // Repeats current rcv_nxt
    } seg_kind_e;

endpackage

/* verilog/tcp_retry_timer.sv */
module tcp_retry_timer #(
    parameter logic [31:0] RTO_CYCLES       = 32'd1000,
    parameter logic [31:0] TIME_WAIT_CYCLES = 32'd2000,
    parameter logic [3:0]  MAX_RETRIES      = 4'd3
) (
    input  logic clk,
    input  logic rst_n,
    input  logic start_rto,             // Arm retransmission countdown
    input  logic start_tw,              // Arm TIME_WAIT countdown
    input  logic stop,                  // Disarm
    output logic expired,
    output logic give_up
);

    logic [31:0] count_q;
    logic        running_q;
    logic        tw_q;                  // Current run is TIME_WAIT
    logic [3:0]  attempts_q;            // Retries already spent
    logic        at_zero;

    assign at_zero = running_q && (count_q == 32'd0);
    // TIME_WAIT never gives up, it just ends
    assign expired = at_zero && (tw_q || (attempts_q < MAX_RETRIES));
    assign give_up = at_zero && !tw_q && (attempts_q >= MAX_RETRIES);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count_q    <= 32'd0;
            running_q  <= 1'b0;
            tw_q       <= 1'b0;
            attempts_q <= 4'd0;
        end else if (stop) begin
            running_q <= 1'b0;
        end else if (start_rto) begin
            count_q    <= RTO_CYCLES;
            running_q  <= 1'b1;
            tw_q       <= 1'b0;
            attempts_q <= expired ? attempts_q + 4'd1 : 4'd0; // Restart on expiry is a retry
        end else if (start_tw) begin
            count_q   <= TIME_WAIT_CYCLES;
            running_q <= 1'b1;
            tw_q      <= 1'b1;
        end else if (at_zero) begin
            running_q <= 1'b0;
        end else if (running_q) begin
            count_q <= count_q - 32'd1;
        end
    end

endmodule

/* verilog/tcp_seq_tracker.sv */
module tcp_seq_tracker #(
    parameter logic [tcp_pkg::SEQ_W-1:0] ISN = 32'h1234_5678
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        seg_load,  // Build header this cycle
    input  tcp_pkg::seg_kind_e          seg_kind,
    input  logic                        rcv_take,  // Consume peer sequence space
    input  logic [tcp_pkg::LEN_W-1:0]   cmd_len,
    input  logic [tcp_pkg::SEQ_W-1:0]   meta_seq,
    input  logic [tcp_pkg::SEQ_W-1:0]   meta_ack,
    input  logic [tcp_pkg::LEN_W-1:0]   meta_len,
    output logic [tcp_pkg::SEQ_W-1:0]   seg_seq,
    output logic [tcp_pkg::SEQ_W-1:0]   seg_ack,
    output logic [tcp_pkg::FLAG_W-1:0]  seg_flags,
    output logic [tcp_pkg::LEN_W-1:0]   seg_len,
    output logic                        ack_match,
    output logic                        seq_in_order,
    output logic                        has_payload
);

    logic [tcp_pkg::SEQ_W-1:0]  snd_nxt_q;             // Next seq we send
    logic [tcp_pkg::SEQ_W-1:0]  rcv_nxt_q;             // Next seq we expect
    logic [tcp_pkg::SEQ_W-1:0]  snd_nxt_d;
    logic [tcp_pkg::SEQ_W-1:0]  rcv_nxt_d;
    logic [tcp_pkg::SEQ_W-1:0]  cmd_len_ext;
    logic [tcp_pkg::SEQ_W-1:0]  meta_len_ext;
    logic [tcp_pkg::SEQ_W-1:0]  seq_d;
    logic [tcp_pkg::SEQ_W-1:0]  ack_d;
    logic [tcp_pkg::FLAG_W-1:0] flags_d;
    logic [tcp_pkg::LEN_W-1:0]  len_d;

    assign cmd_len_ext  = {{(tcp_pkg::SEQ_W - tcp_pkg::LEN_W){1'b0}}, cmd_len};
    assign meta_len_ext = {{(tcp_pkg::SEQ_W - tcp_pkg::LEN_W){1'b0}}, meta_len};

    // Compares for the FSM
    assign ack_match    = (meta_ack == snd_nxt_q);
    assign seq_in_order = (meta_seq == rcv_nxt_q);
    assign has_payload  = (meta_len != '0);

    // SYN/FIN take one number, data takes its length
    always_comb begin
        rcv_nxt_d = rcv_nxt_q;
        if (rcv_take) begin
            rcv_nxt_d = has_payload ? meta_seq + meta_len_ext : meta_seq + 32'd1;
        end
    end

    // ------------------------------------------------------------------------
    // Header for the requested kind
    // ------------------------------------------------------------------------
    always_comb begin
        seq_d     = snd_nxt_q;
        ack_d     = rcv_nxt_d;          // Sees a same-cycle rcv_take
        flags_d   = '0;
        len_d     = '0;
        snd_nxt_d = snd_nxt_q;
        flags_d[tcp_pkg::FLAG_ACK] = 1'b1;
        case (seg_kind)
            tcp_pkg::SYN: begin
                seq_d     = ISN;
                ack_d     = '0;
                flags_d   = '0;
                snd_nxt_d = ISN + 32'd1;        // SYN takes one number
                flags_d[tcp_pkg::FLAG_SYN] = 1'b1;
            end
            tcp_pkg::DATA: begin
                len_d     = cmd_len;
                snd_nxt_d = snd_nxt_q + cmd_len_ext;
                flags_d[tcp_pkg::FLAG_PSH] = 1'b1;
            end
            tcp_pkg::FIN: begin
                snd_nxt_d = snd_nxt_q + 32'd1;  // FIN takes one number
                flags_d[tcp_pkg::FLAG_FIN] = 1'b1;
            end
            default: ;                          // ACK and DUP_ACK
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            snd_nxt_q <= '0;
            rcv_nxt_q <= '0;
        end else begin
            rcv_nxt_q <= rcv_nxt_d;
            if (seg_load) snd_nxt_q <= snd_nxt_d;
        end
    end

    // Held for retries and while the sender works
    always_ff @(posedge clk) begin
        if (seg_load) begin
            seg_seq   <= seq_d;
            seg_ack   <= ack_d;
            seg_flags <= flags_d;
            seg_len   <= len_d;
        end
    end

endmodule

/* verilog/tcp_conn_fsm.sv */
module tcp_conn_fsm (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        cmd_valid,
    input  tcp_pkg::cmd_op_e            cmd_op,
    input  logic                        meta_valid,
    input  logic [tcp_pkg::FLAG_W-1:0]  meta_flags,
    input  logic                        seg_busy,
    input  logic                        ack_match,     // Peer acks snd_nxt
    input  logic                        seq_in_order,  // Peer seq is rcv_nxt
    input  logic                        has_payload,
    input  logic                        expired,
    input  logic                        give_up,
    output logic                        cmd_ready,
    output logic                        meta_ready,
    output logic                        seg_start,
    output logic                        seg_load,
    output tcp_pkg::seg_kind_e          seg_kind,
    output logic                        rcv_take,
    output logic                        timer_start_rto,
    output logic                        timer_start_tw,
    output logic                        timer_stop,
    output tcp_pkg::tcp_state_e         conn_state
);

    tcp_pkg::tcp_state_e state_q, state_d;
    tcp_pkg::tcp_state_e ret_q, ret_d;  // State after the send completes
    logic                cmd_en_q;
    logic                meta_en_q;
    logic                cmd_fire;
    logic                meta_fire;
    logic                is_rst, is_syn, is_ack, is_fin;

    assign is_rst = meta_flags[tcp_pkg::FLAG_RST];
    assign is_syn = meta_flags[tcp_pkg::FLAG_SYN];
    assign is_ack = meta_flags[tcp_pkg::FLAG_ACK];
    assign is_fin = meta_flags[tcp_pkg::FLAG_FIN];

    // Received segments win over commands
    assign meta_ready = meta_en_q;
    assign cmd_ready  = cmd_en_q && !(meta_valid && meta_en_q);
    assign cmd_fire   = cmd_valid && cmd_ready;
    assign meta_fire  = meta_valid && meta_ready;
    assign seg_start  = (state_q == tcp_pkg::SEND_SEG);
    assign conn_state = state_q;

    // ------------------------------------------------------------------------
    // Transition rules
    // ------------------------------------------------------------------------
    always_comb begin
        state_d         = state_q;
        ret_d           = ret_q;
        seg_load        = 1'b0;
        seg_kind        = tcp_pkg::ACK;
        rcv_take        = 1'b0;
        timer_start_rto = 1'b0;
        timer_start_tw  = 1'b0;
        timer_stop      = 1'b0;
        case (state_q)
            tcp_pkg::CLOSED: begin
                if (cmd_fire && cmd_op == tcp_pkg::CONNECT) begin
                    seg_load        = 1'b1;
                    seg_kind        = tcp_pkg::SYN;
                    timer_start_rto = 1'b1;
                    state_d         = tcp_pkg::SEND_SEG;
                    ret_d           = tcp_pkg::SYN_SENT;
                end
            end
            tcp_pkg::SYN_SENT: begin
                if (meta_fire && is_rst) begin      // Refused
                    timer_stop = 1'b1;
                    state_d    = tcp_pkg::CLOSED;
                end else if (meta_fire && is_syn && is_ack && ack_match) begin
                    rcv_take   = 1'b1;              // Peer ISN + 1
                    seg_load   = 1'b1;
                    timer_stop = 1'b1;
                    state_d    = tcp_pkg::SEND_SEG;
                    ret_d      = tcp_pkg::ESTABLISHED;
                end else if (give_up) begin
                    state_d = tcp_pkg::CLOSED;
                end else if (expired) begin         // Resend stored SYN
                    timer_start_rto = 1'b1;
                    state_d         = tcp_pkg::SEND_SEG;
                    ret_d           = tcp_pkg::SYN_SENT;
                end
            end
            tcp_pkg::ESTABLISHED: begin
                ret_d = tcp_pkg::ESTABLISHED;
                if (meta_fire) begin
                    if (is_rst) begin
                        state_d = tcp_pkg::CLOSED;
                    end else if (has_payload) begin
                        seg_load = 1'b1;
                        state_d  = tcp_pkg::SEND_SEG;
                        rcv_take = seq_in_order;    // Out of order keeps rcv_nxt
                        seg_kind = seq_in_order ? tcp_pkg::ACK : tcp_pkg::DUP_ACK;
                    end                             // Pure ACK needs no reply
                end else if (cmd_fire && cmd_op == tcp_pkg::SEND) begin
                    seg_load = 1'b1;
                    seg_kind = tcp_pkg::DATA;
                    state_d  = tcp_pkg::SEND_SEG;
                end else if (cmd_fire && cmd_op == tcp_pkg::CLOSE) begin
                    seg_load        = 1'b1;
                    seg_kind        = tcp_pkg::FIN;
                    timer_start_rto = 1'b1;
                    state_d         = tcp_pkg::SEND_SEG;
                    ret_d           = tcp_pkg::FIN_WAIT_1;
                end
            end
            tcp_pkg::FIN_WAIT_1: begin
                if (meta_fire && is_rst) begin
                    timer_stop = 1'b1;
                    state_d    = tcp_pkg::CLOSED;
                end else if (meta_fire && is_ack && ack_match) begin
                    timer_stop = 1'b1;              // Our FIN is acked
                    state_d    = tcp_pkg::FIN_WAIT_2;
                end else if (give_up) begin
                    state_d = tcp_pkg::CLOSED;
                end else if (expired) begin         // Resend stored FIN
                    timer_start_rto = 1'b1;
                    state_d         = tcp_pkg::SEND_SEG;
                    ret_d           = tcp_pkg::FIN_WAIT_1;
                end
            end
            tcp_pkg::FIN_WAIT_2: begin
                if (meta_fire && is_rst) begin
                    state_d = tcp_pkg::CLOSED;
                end else if (meta_fire && is_fin) begin
                    rcv_take       = 1'b1;          // Peer FIN + 1
                    seg_load       = 1'b1;
                    timer_start_tw = 1'b1;
                    state_d        = tcp_pkg::SEND_SEG;
                    ret_d          = tcp_pkg::TIME_WAIT;
                end
            end
            tcp_pkg::TIME_WAIT: if (expired) state_d = tcp_pkg::CLOSED;
            tcp_pkg::SEND_SEG:  state_d = tcp_pkg::WAIT_SEND;
            tcp_pkg::WAIT_SEND: if (!seg_busy) state_d = ret_q;
            default:            state_d = tcp_pkg::CLOSED;
        endcase
    end

    // Ready levels registered from the next state, low through reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q   <= tcp_pkg::CLOSED;
            ret_q     <= tcp_pkg::CLOSED;
            cmd_en_q  <= 1'b0;
            meta_en_q <= 1'b0;
        end else begin
            state_q   <= state_d;
            ret_q     <= ret_d;
            cmd_en_q  <= (state_d == tcp_pkg::CLOSED) || (state_d == tcp_pkg::ESTABLISHED);
            meta_en_q <= state_d inside {tcp_pkg::SYN_SENT, tcp_pkg::ESTABLISHED,
                                         tcp_pkg::FIN_WAIT_1, tcp_pkg::FIN_WAIT_2};
        end
    end

endmodule

/* verilog/tcp_conn_ctrl.sv */
module tcp_conn_ctrl #(
    parameter logic [tcp_pkg::SEQ_W-1:0] ISN              = 32'h1234_5678,
    parameter logic [31:0]               RTO_CYCLES       = 32'd1000,
    parameter logic [31:0]               TIME_WAIT_CYCLES = 32'd2000,
    parameter logic [3:0]                MAX_RETRIES      = 4'd3
) (
    input  logic                        clk,
    input  logic                        rst_n,
    // Application commands
    input  logic                        cmd_valid,
    output logic                        cmd_ready,
    input  tcp_pkg::cmd_op_e            cmd_op,
    input  logic [tcp_pkg::LEN_W-1:0]   cmd_len,
    // Parsed incoming segment
    input  logic                        meta_valid,
    output logic                        meta_ready,
    input  logic [tcp_pkg::SEQ_W-1:0]   meta_seq,
    input  logic [tcp_pkg::SEQ_W-1:0]   meta_ack,
    input  logic [tcp_pkg::FLAG_W-1:0]  meta_flags,
    input  logic [tcp_pkg::LEN_W-1:0]   meta_len,
    // Outgoing segment to sender
    output logic                        seg_start,
    output logic [tcp_pkg::SEQ_W-1:0]   seg_seq,
    output logic [tcp_pkg::SEQ_W-1:0]   seg_ack,
    output logic [tcp_pkg::FLAG_W-1:0]  seg_flags,
    output logic [tcp_pkg::LEN_W-1:0]   seg_len,
    input  logic                        seg_busy,
    output tcp_pkg::tcp_state_e         conn_state
);

    tcp_pkg::seg_kind_e seg_kind;
    logic seg_load, rcv_take;
    logic ack_match, seq_in_order, has_payload;
    logic timer_start_rto, timer_start_tw, timer_stop;
    logic expired, give_up;

    tcp_conn_fsm u_fsm (.*);

    tcp_seq_tracker #(.ISN(ISN)) u_tracker (.*);

    tcp_retry_timer #(
        .RTO_CYCLES       (RTO_CYCLES),
        .TIME_WAIT_CYCLES (TIME_WAIT_CYCLES),
        .MAX_RETRIES      (MAX_RETRIES)
    ) u_timer (
        .clk       (clk),
        .rst_n     (rst_n),
        .start_rto (timer_start_rto),
        .start_tw  (timer_start_tw),
        .stop      (timer_stop),
        .expired   (expired),
        .give_up   (give_up)
    );

endmodule

/* testbench/tcp_conn_ctrl_checker.sv */
module tcp_conn_ctrl_checker (
    input logic clk,
    input logic rst_n,
    input logic seg_start,
    input logic seg_busy,
    input logic cmd_ready,
    input logic meta_ready
);

    // Start is a single-cycle pulse
    a_start_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        seg_start |=> !seg_start)
        else $error("seg_start stayed high for two cycles");

    // New segment only once the sender is free
    a_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(seg_start) |-> !seg_busy)
        else $error("seg_start rose while seg_busy was high");

    // Both inputs closed while the FSM waits on the sender
    a_ready_low: assert property (@(posedge clk) disable iff (!rst_n)
        seg_start |=> (!cmd_ready && !meta_ready))
        else $error("ready high in the cycle after seg_start");

endmodule

bind tcp_conn_ctrl tcp_conn_ctrl_checker u_checker (
    .clk        (clk),
    .rst_n      (rst_n),
    .seg_start  (seg_start),
    .seg_busy   (seg_busy),
    .cmd_ready  (cmd_ready),
    .meta_ready (meta_ready)
);

/* testbench/tcp_conn_ctrl_tb.sv */
module tcp_conn_ctrl_tb;

    localparam logic [31:0] ISN         = 32'h1234_5678; // Initial send sequence
    localparam logic [3:0]  MAX_RETRIES = 4'd3;

    logic                        clk;
    logic                        rst_n;
    logic                        cmd_valid;
    logic                        cmd_ready;
    tcp_pkg::cmd_op_e            cmd_op;
    logic [tcp_pkg::LEN_W-1:0]   cmd_len;
    logic                        meta_valid;
    logic                        meta_ready;
    logic [tcp_pkg::SEQ_W-1:0]   meta_seq;
    logic [tcp_pkg::SEQ_W-1:0]   meta_ack;
    logic [tcp_pkg::FLAG_W-1:0]  meta_flags;
    logic [tcp_pkg::LEN_W-1:0]   meta_len;
    logic                        seg_start;
    logic [tcp_pkg::SEQ_W-1:0]   seg_seq;
    logic [tcp_pkg::SEQ_W-1:0]   seg_ack;
    logic [tcp_pkg::FLAG_W-1:0]  seg_flags;
    logic [tcp_pkg::LEN_W-1:0]   seg_len;
    logic                        seg_busy;
    tcp_pkg::tcp_state_e         conn_state;

    int          seed = 32'h6e1a_ae73;  // Sender busy time
    int          hold;
    int          seg_count = 0;         // seg_start pulses seen so far
    logic [31:0] cap_seq, cap_ack, cap_flags, cap_len; // Last header seen
    int          cycles = 0;
    int          cycle_limit = 0;       // Set once the vectors are known
    logic [31:0] vec [0:63][0:12];      // One row per step, columns as in the file
    int          n_steps;

    tcp_conn_ctrl #(
        .ISN              (ISN),
        .RTO_CYCLES       (32'd20),
        .TIME_WAIT_CYCLES (32'd30),
        .MAX_RETRIES      (MAX_RETRIES)
    ) u_tcp_conn_ctrl (.*);

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // ------------------------------------------------------------------------
    // Sender model, header captured mid-cycle while seg_start is high
    // ------------------------------------------------------------------------
    always begin
        @(negedge clk);
        if (rst_n && seg_start) begin
            cap_seq   = seg_seq;
            cap_ack   = seg_ack;
            cap_flags = 32'(seg_flags);
            cap_len   = 32'(seg_len);
            seg_count = seg_count + 1;
            hold      = 1 + ($random(seed) & 3); // 1 to 4 busy cycles
            @(posedge clk);
            #1 seg_busy = 1'b1;
            repeat (hold) @(posedge clk);
            #1 seg_busy = 1'b0;
        end
    end

    // Run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("Timeout after %0d cycles, the DUT stopped making progress", cycles);
            $display("TEST FAIL");
            $fatal(1, "timeout");
        end
    end

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%08h expected 0x%08h", name, got, exp);
            $display("TEST FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    // Lines starting with # are comments
    task automatic load_vectors();
        int    fd;
        int    got;
        string line;
        fd = $fopen("testbench/tcp_conn_vectors.txt", "r");
        if (fd == 0) begin
            $display("Could not open the vector file testbench/tcp_conn_vectors.txt");
            $display("TEST FAIL");
            $fatal(1, "no vector file");
        end
        n_steps = 0;
        while (!$feof(fd) && n_steps < 64) begin
            line = "";
            got  = $fgets(line, fd);
            if (got > 0 && line.len() > 1 && line[0] != 8'h23) begin
                got = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
                    vec[n_steps][0], vec[n_steps][1], vec[n_steps][2], vec[n_steps][3],
                    vec[n_steps][4], vec[n_steps][5], vec[n_steps][6], vec[n_steps][7],
                    vec[n_steps][8], vec[n_steps][9], vec[n_steps][10],
                    vec[n_steps][11], vec[n_steps][12]);
                if (got != 13) begin
                    $display("Vector line %0d has %0d fields instead of 13", n_steps, got);
                    $display("TEST FAIL");
                    $fatal(1, "bad vector line");
                end
                n_steps++;
            end
        end
        $fclose(fd);
    endtask

    // ------------------------------------------------------------------------
    // One step: transfer, then wait for the segments and the final state
    // ------------------------------------------------------------------------
    task automatic run_step(input int i);
        int base;
        base = seg_count;
        if (vec[i][0] != 32'd2) begin           // 2 is an idle wait
            @(posedge clk);
            #1;
            if (vec[i][0] == 32'd0) begin
                cmd_valid = 1'b1;
                cmd_op    = tcp_pkg::cmd_op_e'(vec[i][1][1:0]);
                cmd_len   = vec[i][2][15:0];
            end else begin
                meta_valid = 1'b1;
                meta_seq   = vec[i][3];
                meta_ack   = vec[i][4];
                meta_flags = vec[i][5][7:0];
                meta_len   = vec[i][6][15:0];
            end
            @(negedge clk);
            while (!(cmd_valid && cmd_ready) && !(meta_valid && meta_ready)) @(negedge clk);
            @(posedge clk);                     // Transfer edge
            #1;
            cmd_valid  = 1'b0;
            meta_valid = 1'b0;
        end
        while (seg_count - base < vec[i][7] ||
               conn_state != tcp_pkg::tcp_state_e'(vec[i][12][3:0])) begin
            @(posedge clk);
            #1;
        end
        compare_value("seg_start count", 32'(seg_count - base), vec[i][7]);
        if (vec[i][7] != 32'd0) begin
            compare_value("seg_seq", cap_seq, vec[i][8]);
            compare_value("seg_ack", cap_ack, vec[i][9]);
            compare_value("seg_flags", cap_flags, vec[i][10]);
            compare_value("seg_len", cap_len, vec[i][11]);
        end
    endtask

    // ------------------------------------------------------------------------
    // CONNECT with no reply: first SYN plus every retry, then back to CLOSED
    // ------------------------------------------------------------------------
    task automatic check_syn_give_up();
        int base;
        base = seg_count;
        @(posedge clk);
        #1;
        cmd_valid = 1'b1;
        cmd_op    = tcp_pkg::CONNECT;
        cmd_len   = '0;
        @(negedge clk);
        while (!cmd_ready) @(negedge clk);
        @(posedge clk);                         // Transfer edge
        #1;
        cmd_valid = 1'b0;
        while (seg_count == base || conn_state != tcp_pkg::CLOSED) begin
            @(posedge clk);
            #1;
        end
        compare_value("seg_start count", 32'(seg_count - base), 32'(MAX_RETRIES) + 32'd1);
        compare_value("seg_seq", cap_seq, ISN);
        compare_value("seg_flags", cap_flags, 32'h02); // SYN alone
        compare_value("seg_len", cap_len, 32'd0);
    endtask

    initial begin
        rst_n      = 1'b0;
        cmd_valid  = 1'b0;
        cmd_op     = tcp_pkg::CONNECT;
        cmd_len    = '0;
        meta_valid = 1'b0;
        meta_seq   = '0;
        meta_ack   = '0;
        meta_flags = '0;
        meta_len   = '0;
        seg_busy   = 1'b0;
        load_vectors();
        cycle_limit = 50 * n_steps + 2 * 20 * 4; // Per step plus two SYN retry runs
        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;
        for (int i = 0; i < n_steps; i++) begin
            run_step(i);
        end
        check_syn_give_up();
        @(posedge clk);
        $display("TEST PASS");
        $finish;
    end

endmodule

/* testbench/tcp_conn_vectors.txt */
# type(0 cmd, 1 segment in, 2 idle) op cmd_len meta_seq meta_ack meta_flags meta_len
# then n_seg exp_seq exp_ack exp_flags exp_len exp_state, all hex
# handshake and data
0 0 0000 00000000 00000000 00 0000 1 12345678 00000000 02 0000 1
1 0 0000 a0000000 12345679 12 0000 1 12345679 a0000001 10 0000 2
0 1 0100 00000000 00000000 00 0000 1 12345679 a0000001 18 0100 2
0 1 0040 00000000 00000000 00 0000 1 12345779 a0000001 18 0040 2
1 0 0000 a0000001 123457b9 18 0080 1 123457b9 a0000081 10 0000 2
1 0 0000 a0000200 123457b9 18 0020 1 123457b9 a0000081 10 0000 2
1 0 0000 a0000081 123457b9 10 0000 0 00000000 00000000 00 0000 2
# active close
0 2 0000 00000000 00000000 00 0000 1 123457b9 a0000081 11 0000 3
1 0 0000 a0000081 123457ba 10 0000 0 00000000 00000000 00 0000 4
1 0 0000 a0000081 123457ba 11 0000 1 123457ba a0000082 10 0000 5
2 0 0000 00000000 00000000 00 0000 0 00000000 00000000 00 0000 0
# unanswered SYN, then refused
0 0 0000 00000000 00000000 00 0000 4 12345678 00000000 02 0000 1
1 0 0000 00000000 00000000 04 0000 0 00000000 00000000 00 0000 0
# reset by peer
0 0 0000 00000000 00000000 00 0000 1 12345678 00000000 02 0000 1
1 0 0000 b0000000 12345679 12 0000 1 12345679 b0000001 10 0000 2
1 0 0000 00000000 00000000 04 0000 0 00000000 00000000 00 0000 0

/* tb.f */
verilog/tcp_pkg.sv
verilog/tcp_retry_timer.sv
verilog/tcp_seq_tracker.sv
verilog/tcp_conn_fsm.sv
verilog/tcp_conn_ctrl.sv
testbench/tcp_conn_ctrl_checker.sv
testbench/tcp_conn_ctrl_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tcp_conn_ctrl_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)
